// File: source/dcachePkg.sv
package dcachePkg;

  // request and memory widths
  localparam int AddrWidth = 32;
  localparam int DataWidth = 64;
  localparam int MaskWidth = DataWidth / 8;

  // line geometry, 2 ways of 64 sets with 32-byte lines
  localparam int LineWidth = 256;
  localparam int BeatsPerLine = LineWidth / DataWidth;
  localparam int NumSets = 64;
  localparam int IndexWidth = 6;
  localparam int OffsetWidth = 5;
  localparam int TagWidth = AddrWidth - IndexWidth - OffsetWidth;

  // one address word, seen flat for the memory bus
  // or split into its cache fields for lookup
  typedef union packed {
    logic [AddrWidth-1:0] word;
    struct packed {
      logic [TagWidth-1:0]   tag;
      logic [IndexWidth-1:0] index;
      logic [1:0]            wordSel;
      logic [2:0]            byteOff;
    } fields;
  } cacheAddr_u;

  // word 0 sits in the low bits, same order as refill beats
  typedef logic [BeatsPerLine-1:0][DataWidth-1:0] line_t;

endpackage

// File: source/refillBuffer.sv
`timescale 1ns/1ns

module refillBuffer import dcachePkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 refillEn_i,
  input  logic                 beatValid_i,
  input  logic [DataWidth-1:0] beatData_i,
  input  logic                 beatLast_i,
  output line_t                line_o,
  output logic                 last_o
);

  logic [$clog2(BeatsPerLine)-1:0] beatCnt;
  logic                            beatTake;

  assign beatTake = refillEn_i && beatValid_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCnt <= '0;
      last_o <= 1'b0;
    end else begin
      last_o <= beatTake && beatLast_i;
      // back to slot 0 once the burst is complete
      if (!refillEn_i || (beatTake && beatLast_i)) begin
        beatCnt <= '0;
      end else if (beatTake) begin
        beatCnt <= beatCnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (beatTake) begin
      line_o[beatCnt] <= beatData_i;
    end
  end

  lastOnFourthBeat: assert property (@(posedge clk) disable iff (!rst_n)
    beatTake |-> (beatLast_i == (beatCnt == BeatsPerLine - 1)));

endmodule

// File: source/tagStore.sv
`timescale 1ns/1ns

module tagStore import dcachePkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [IndexWidth-1:0] index_i,
  input  logic [TagWidth-1:0]   tag_i,
  input  logic                  storeCommit_i,
  input  logic                  install_i,
  output logic                  hit_o,
  output logic                  hitWay_o,
  output logic                  victimWay_o,
  output logic                  victimDirty_o,
  output logic [TagWidth-1:0]   victimTag_o
);

  logic [TagWidth-1:0]   tagMem [2][NumSets];
  logic [1:0][NumSets-1:0] validQ;
  logic [1:0][NumSets-1:0] dirtyQ;
  logic                  victimQ;
  logic [1:0]            wayHit;

  // both ways compared in parallel
  always_comb begin
    for (int w = 0; w < 2; w++) begin
      wayHit[w] = validQ[w][index_i] && (tagMem[w][index_i] == tag_i);
    end
  end

  assign hit_o = |wayHit;
  assign hitWay_o = wayHit[1];

  // victim simply alternates after each refill
  assign victimWay_o = victimQ;
  assign victimTag_o = tagMem[victimQ][index_i];
  assign victimDirty_o = validQ[victimQ][index_i] && dirtyQ[victimQ][index_i];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validQ <= '0;
      dirtyQ <= '0;
      victimQ <= 1'b0;
    end else if (install_i) begin
      // fresh line is clean
      validQ[victimQ][index_i] <= 1'b1;
      dirtyQ[victimQ][index_i] <= 1'b0;
      victimQ <= ~victimQ;
    end else if (storeCommit_i) begin
      dirtyQ[hitWay_o][index_i] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (install_i) begin
      tagMem[victimQ][index_i] <= tag_i;
    end
  end

  // a line is only installed after a miss in both ways
  singleWayHit: assert property (@(posedge clk) disable iff (!rst_n)
    !(wayHit[0] && wayHit[1]));

endmodule

// File: source/dataStore.sv
`timescale 1ns/1ns

module dataStore import dcachePkg::*; (
  input  logic                  clk,
  input  logic [IndexWidth-1:0] index_i,
  input  logic [1:0]            wordSel_i,
  input  logic                  hitWay_i,
  input  logic                  victimWay_i,
  input  logic                  storeCommit_i,
  input  logic [DataWidth-1:0]  storeData_i,
  input  logic [MaskWidth-1:0]  storeMask_i,
  input  logic                  install_i,
  input  line_t                 refillLine_i,
  output logic [DataWidth-1:0]  rdWord_o,
  output line_t                 victimLine_o
);

  line_t                lineMem [2][NumSets];
  line_t                hitLine;
  line_t                mergedLine;
  logic [DataWidth-1:0] byteMask;
  logic [LineWidth-1:0] lineMask;
  logic [LineWidth-1:0] lineData;

  assign hitLine = lineMem[hitWay_i][index_i];
  assign victimLine_o = lineMem[victimWay_i][index_i];
  assign rdWord_o = hitLine[wordSel_i];

  // byte enables widened to bits
  always_comb begin
    for (int b = 0; b < MaskWidth; b++) begin
      byteMask[b*8 +: 8] = {8{storeMask_i[b]}};
    end
  end

  // store word placed at its slot in the line
  always_comb begin
    lineMask = '0;
    lineData = '0;
    lineMask[wordSel_i*DataWidth +: DataWidth] = byteMask;
    lineData[wordSel_i*DataWidth +: DataWidth] = storeData_i;
  end

  assign mergedLine = (hitLine & ~lineMask) | (lineData & lineMask);

  // install and store commit never fall in the same cycle
  always_ff @(posedge clk) begin
    if (install_i) begin
      lineMem[victimWay_i][index_i] <= refillLine_i;
    end else if (storeCommit_i) begin
      lineMem[hitWay_i][index_i] <= mergedLine;
    end
  end

endmodule

// File: source/dcacheCtrl.sv
`timescale 1ns/1ns

module dcacheCtrl import dcachePkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 req_i,
  input  logic                 we_i,
  input  logic [AddrWidth-1:0] addr_i,
  input  logic [DataWidth-1:0] wrData_i,
  input  logic [MaskWidth-1:0] wrMask_i,
  input  logic                 hit_i,
  input  logic                 victimDirty_i,
  input  logic [TagWidth-1:0]  victimTag_i,
  input  logic                 refillLast_i,
  input  logic                 memWrReady_i,
  output cacheAddr_u           reqAddr_o,
  output logic                 reqWe_o,
  output logic [DataWidth-1:0] storeData_o,
  output logic [MaskWidth-1:0] storeMask_o,
  output logic                 storeCommit_o,
  output logic                 install_o,
  output logic                 refillEn_o,
  output logic                 ready_o,
  output logic                 done_o,
  output logic                 memRdValid_o,
  output logic [AddrWidth-1:0] memRdAddr_o,
  output logic                 memWrValid_o,
  output logic [AddrWidth-1:0] memWrAddr_o
);

  localparam logic [2:0] Idle      = 3'd0;
  localparam logic [2:0] Compare   = 3'd1;
  localparam logic [2:0] WriteBack = 3'd2;
  localparam logic [2:0] Refill    = 3'd3;
  localparam logic [2:0] Install   = 3'd4;

  logic [2:0] state;
  logic [2:0] nextState;
  logic       accept;
  cacheAddr_u addrIn;
  cacheAddr_u lineAddr;
  cacheAddr_u victimAddr;

  assign addrIn.word = addr_i;
  assign accept = req_i && ready_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= Idle;
    end else begin
      state <= nextState;
    end
  end

  // a miss goes through writeback if dirty, refill and install before compare again
  always_comb begin
    nextState = state;
    case (state)
      Idle: begin
        if (accept) begin
          nextState = Compare;
        end
      end
      Compare: begin
        if (hit_i) begin
          nextState = Idle;
        end else if (victimDirty_i) begin
          nextState = WriteBack;
        end else begin
          nextState = Refill;
        end
      end
      WriteBack: begin
        if (memWrReady_i) begin
          nextState = Refill;
        end
      end
      Refill: begin
        if (refillLast_i) begin
          nextState = Install;
        end
      end
      Install: nextState = Compare;
      default: nextState = Idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      reqAddr_o <= '0;
      reqWe_o <= 1'b0;
    end else if (accept) begin
      reqAddr_o <= addrIn;
      reqWe_o <= we_i;
    end
  end

  // store bytes moved onto their lanes within the word
  always_ff @(posedge clk) begin
    if (accept) begin
      storeData_o <= wrData_i << {addrIn.fields.byteOff, 3'b000};
      storeMask_o <= wrMask_i << addrIn.fields.byteOff;
    end
  end

  // refill address is the request line
  // victim line swaps in the stored tag
  always_comb begin
    lineAddr = reqAddr_o;
    lineAddr.word[OffsetWidth-1:0] = '0;
    victimAddr = lineAddr;
    victimAddr.fields.tag = victimTag_i;
  end

  assign memRdAddr_o = lineAddr.word;
  assign memWrAddr_o = victimAddr.word;

  assign ready_o = (state == Idle);
  assign done_o = (state == Compare) && hit_i;
  assign storeCommit_o = done_o && reqWe_o;
  assign install_o = (state == Install);
  assign refillEn_o = (state == Refill);
  // request drops once the last beat is in the buffer
  assign memRdValid_o = refillEn_o && !refillLast_i;
  assign memWrValid_o = (state == WriteBack);

  // a freshly installed line hits on the compare right after
  installThenHit: assert property (@(posedge clk) disable iff (!rst_n)
    install_o |=> done_o);

endmodule

// File: source/dcacheTop.sv
`timescale 1ns/1ns

module dcacheTop import dcachePkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  // pipeline side
  input  logic                 req_i,
  input  logic                 we_i,
  input  logic [AddrWidth-1:0] addr_i,
  input  logic [DataWidth-1:0] wrData_i,
  input  logic [MaskWidth-1:0] wrMask_i,
  output logic                 ready_o,
  output logic                 done_o,
  output logic [DataWidth-1:0] rdData_o,
  // memory side
  output logic                 memRdValid_o,
  output logic [AddrWidth-1:0] memRdAddr_o,
  input  logic [DataWidth-1:0] memRdData_i,
  input  logic                 memRdDataValid_i,
  input  logic                 memRdLast_i,
  output logic                 memWrValid_o,
  output logic [AddrWidth-1:0] memWrAddr_o,
  output line_t                memWrData_o,
  input  logic                 memWrReady_i
);

  cacheAddr_u           reqAddr;
  logic [DataWidth-1:0] storeData;
  logic [MaskWidth-1:0] storeMask;
  logic                 storeCommit;
  logic                 install;
  logic                 refillEn;
  logic                 hit;
  logic                 hitWay;
  logic                 victimWay;
  logic                 victimDirty;
  logic [TagWidth-1:0]  victimTag;
  line_t                refillLine;
  logic                 refillLast;

  dcacheCtrl u_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_i         (req_i),
    .we_i          (we_i),
    .addr_i        (addr_i),
    .wrData_i      (wrData_i),
    .wrMask_i      (wrMask_i),
    .hit_i         (hit),
    .victimDirty_i (victimDirty),
    .victimTag_i   (victimTag),
    .refillLast_i  (refillLast),
    .memWrReady_i  (memWrReady_i),
    .reqAddr_o     (reqAddr),
    .reqWe_o       (),
    .storeData_o   (storeData),
    .storeMask_o   (storeMask),
    .storeCommit_o (storeCommit),
    .install_o     (install),
    .refillEn_o    (refillEn),
    .ready_o       (ready_o),
    .done_o        (done_o),
    .memRdValid_o  (memRdValid_o),
    .memRdAddr_o   (memRdAddr_o),
    .memWrValid_o  (memWrValid_o),
    .memWrAddr_o   (memWrAddr_o)
  );

  tagStore u_tags (
    .clk           (clk),
    .rst_n         (rst_n),
    .index_i       (reqAddr.fields.index),
    .tag_i         (reqAddr.fields.tag),
    .storeCommit_i (storeCommit),
    .install_i     (install),
    .hit_o         (hit),
    .hitWay_o      (hitWay),
    .victimWay_o   (victimWay),
    .victimDirty_o (victimDirty),
    .victimTag_o   (victimTag)
  );

  dataStore u_data (
    .clk           (clk),
    .index_i       (reqAddr.fields.index),
    .wordSel_i     (reqAddr.fields.wordSel),
    .hitWay_i      (hitWay),
    .victimWay_i   (victimWay),
    .storeCommit_i (storeCommit),
    .storeData_i   (storeData),
    .storeMask_i   (storeMask),
    .install_i     (install),
    .refillLine_i  (refillLine),
    .rdWord_o      (rdData_o),
    .victimLine_o  (memWrData_o)
  );

  refillBuffer u_refill (
    .clk         (clk),
    .rst_n       (rst_n),
    .refillEn_i  (refillEn),
    .beatValid_i (memRdDataValid_i),
    .beatData_i  (memRdData_i),
    .beatLast_i  (memRdLast_i),
    .line_o      (refillLine),
    .last_o      (refillLast)
  );

endmodule

// File: bench/tbMemory.sv
`timescale 1ns/1ns

module tbMemory import dcachePkg::*; (
  input  logic                 clk,
  input  logic                 memRdValid_i,
  input  logic [AddrWidth-1:0] memRdAddr_i,
  output logic [DataWidth-1:0] memRdData_o,
  output logic                 memRdDataValid_o,
  output logic                 memRdLast_o,
  input  logic                 memWrValid_i,
  input  logic [AddrWidth-1:0] memWrAddr_i,
  input  line_t                memWrData_i,
  output logic                 memWrReady_o
);

  // sparse store keyed by word address, untouched words come from the fill pattern
  logic [DataWidth-1:0] mem [logic [AddrWidth-1:0]];
  logic [31:0]          rngState = 32'd78318;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [DataWidth-1:0] readWord(input logic [AddrWidth-1:0] a);
    if (mem.exists(a)) begin
      return mem[a];
    end
    return {a ^ 32'h9E37_79B9, ~a};
  endfunction

  // zero to three idle cycles
  task automatic drawDelay(output int unsigned delay);
    rngState = xorshift32(rngState);
    delay = rngState[1:0];
  endtask

  initial begin : readPort
    logic [AddrWidth-1:0] base;
    int unsigned          delay;
    memRdData_o = '0;
    memRdDataValid_o = 1'b0;
    memRdLast_o = 1'b0;
    forever begin
      @(negedge clk);
      if (memRdValid_i) begin
        base = memRdAddr_i;
        drawDelay(delay);
        repeat (delay) @(negedge clk);
        for (int beat = 0; beat < BeatsPerLine; beat++) begin
          memRdData_o = readWord(base + AddrWidth'(8 * beat));
          memRdDataValid_o = 1'b1;
          memRdLast_o = (beat == BeatsPerLine - 1);
          @(negedge clk);
          memRdDataValid_o = 1'b0;
          memRdLast_o = 1'b0;
          drawDelay(delay);
          // occasional gap between beats
          if (delay == 0 && beat != BeatsPerLine - 1) begin
            @(negedge clk);
          end
        end
      end
    end
  end

  initial begin : writePort
    int unsigned delay;
    memWrReady_o = 1'b0;
    forever begin
      @(negedge clk);
      if (memWrValid_i) begin
        drawDelay(delay);
        repeat (delay) @(negedge clk);
        for (int w = 0; w < BeatsPerLine; w++) begin
          mem[memWrAddr_i + AddrWidth'(8 * w)] = memWrData_i[w];
        end
        memWrReady_o = 1'b1;
        @(negedge clk);
        memWrReady_o = 1'b0;
      end
    end
  end

endmodule

// File: bench/dcacheTb.sv
`timescale 1ns/1ns

module dcacheTb import dcachePkg::*; ();

  localparam int ClkPeriod = 40;
  localparam int NumEntries = 16;
  // generous cycle budget for a dirty miss against slow memory
  localparam int MissBound = 40;

  logic                 clk;
  logic                 rst_n;
  logic                 req;
  logic                 we;
  logic [AddrWidth-1:0] addr;
  logic [DataWidth-1:0] wrData;
  logic [MaskWidth-1:0] wrMask;
  logic                 ready;
  logic                 done;
  logic [DataWidth-1:0] rdData;
  logic                 memRdValid;
  logic [AddrWidth-1:0] memRdAddr;
  logic [DataWidth-1:0] memRdData;
  logic                 memRdDataValid;
  logic                 memRdLast;
  logic                 memWrValid;
  logic [AddrWidth-1:0] memWrAddr;
  line_t                memWrData;
  logic                 memWrReady;

  // stimulus table, one request per row
  logic                 stimWe   [NumEntries];
  logic [AddrWidth-1:0] stimAddr [NumEntries];
  logic [DataWidth-1:0] stimData [NumEntries];
  logic [MaskWidth-1:0] stimMask [NumEntries];
  logic                 stimHit  [NumEntries];

  // architectural memory where unstored words read as the fill pattern
  logic [DataWidth-1:0] refMem [logic [AddrWidth-1:0]];
  logic [AddrWidth-1:0] curAddr = '0;
  int                   dataErrors = 0;
  int                   busErrors = 0;

  dcacheTop u_dut (
    .clk              (clk),
    .rst_n            (rst_n),
    .req_i            (req),
    .we_i             (we),
    .addr_i           (addr),
    .wrData_i         (wrData),
    .wrMask_i         (wrMask),
    .ready_o          (ready),
    .done_o           (done),
    .rdData_o         (rdData),
    .memRdValid_o     (memRdValid),
    .memRdAddr_o      (memRdAddr),
    .memRdData_i      (memRdData),
    .memRdDataValid_i (memRdDataValid),
    .memRdLast_i      (memRdLast),
    .memWrValid_o     (memWrValid),
    .memWrAddr_o      (memWrAddr),
    .memWrData_o      (memWrData),
    .memWrReady_i     (memWrReady)
  );

  tbMemory u_mem (
    .clk              (clk),
    .memRdValid_i     (memRdValid),
    .memRdAddr_i      (memRdAddr),
    .memRdData_o      (memRdData),
    .memRdDataValid_o (memRdDataValid),
    .memRdLast_o      (memRdLast),
    .memWrValid_i     (memWrValid),
    .memWrAddr_i      (memWrAddr),
    .memWrData_i      (memWrData),
    .memWrReady_o     (memWrReady)
  );

  function automatic logic [DataWidth-1:0] refWord(input logic [AddrWidth-1:0] a);
    if (refMem.exists(a)) begin
      return refMem[a];
    end
    return {a ^ 32'h9E37_79B9, ~a};
  endfunction

  // data byte b lands on lane b plus the byte offset and lanes past 7 fall off
  task automatic applyStore(input logic [AddrWidth-1:0] a, input logic [DataWidth-1:0] data,
                            input logic [MaskWidth-1:0] mask);
    logic [AddrWidth-1:0] wordAddr;
    logic [DataWidth-1:0] word;
    int                   lane;
    wordAddr = {a[AddrWidth-1:3], 3'b000};
    word = refWord(wordAddr);
    for (int b = 0; b < MaskWidth; b++) begin
      lane = b + int'(a[2:0]);
      if (mask[b] && lane < MaskWidth) begin
        word[lane*8 +: 8] = data[b*8 +: 8];
      end
    end
    refMem[wordAddr] = word;
  endtask

  task automatic compareValue(input string name, input logic [DataWidth-1:0] got,
                              input logic [DataWidth-1:0] expected);
    assert (got === expected) else begin
      dataErrors++;
      $display("mismatch %s: got %h expected %h", name, got, expected);
    end
  endtask

  task automatic setEntry(input int i, input logic w, input logic [AddrWidth-1:0] a,
                          input logic [DataWidth-1:0] d, input logic [MaskWidth-1:0] m,
                          input logic h);
    stimWe[i] = w;
    stimAddr[i] = a;
    stimData[i] = d;
    stimMask[i] = m;
    stimHit[i] = h;
  endtask

  // lines A 0x060, B 0x860 and C 0xABCDE060 share set 3 and D sits in set 8
  task automatic loadTable();
    setEntry(0, 1'b0, 32'h0000_0068, 64'h0, 8'h00, 1'b0);
    setEntry(1, 1'b1, 32'h0000_006A, 64'h1122_3344_5566_7788, 8'h0F, 1'b1);
    setEntry(2, 1'b0, 32'h0000_0068, 64'h0, 8'h00, 1'b1);
    setEntry(3, 1'b0, 32'h0000_0110, 64'h0, 8'h00, 1'b0);
    setEntry(4, 1'b1, 32'h0000_0113, 64'h0000_0000_0000_00C3, 8'h01, 1'b1);
    setEntry(5, 1'b0, 32'h0000_0860, 64'h0, 8'h00, 1'b0);
    setEntry(6, 1'b1, 32'h0000_0878, 64'hDEAD_BEEF_CAFE_F00D, 8'hFF, 1'b1);
    setEntry(7, 1'b0, 32'hABCD_E060, 64'h0, 8'h00, 1'b0);
    setEntry(8, 1'b1, 32'hABCD_E064, 64'h0000_0000_A5A5_5A5A, 8'h0F, 1'b1);
    // reloads of evicted dirty lines
    setEntry(9, 1'b0, 32'h0000_0068, 64'h0, 8'h00, 1'b0);
    setEntry(10, 1'b0, 32'h0000_0878, 64'h0, 8'h00, 1'b0);
    setEntry(11, 1'b0, 32'hABCD_E064, 64'h0, 8'h00, 1'b0);
    setEntry(12, 1'b0, 32'h0000_0878, 64'h0, 8'h00, 1'b1);
    // store miss that completes after the refill
    setEntry(13, 1'b1, 32'h0000_0061, 64'h8000_0000_0000_0042, 8'h81, 1'b0);
    setEntry(14, 1'b0, 32'h0000_0113, 64'h0, 8'h00, 1'b1);
    setEntry(15, 1'b0, 32'h0000_0060, 64'h0, 8'h00, 1'b1);
  endtask

  task automatic runEntry(input int i);
    logic [AddrWidth-1:0] wordAddr;
    while (!ready) begin
      @(negedge clk);
    end
    curAddr = stimAddr[i];
    wordAddr = {stimAddr[i][AddrWidth-1:3], 3'b000};
    req = 1'b1;
    we = stimWe[i];
    addr = stimAddr[i];
    wrData = stimData[i];
    wrMask = stimMask[i];
    @(negedge clk);
    req = 1'b0;
    // a hit answers in the cycle right after acceptance
    compareValue("done_o", done, stimHit[i]);
    while (!done) begin
      @(negedge clk);
    end
    if (stimWe[i]) begin
      applyStore(stimAddr[i], stimData[i], stimMask[i]);
    end else begin
      compareValue("rdData_o", rdData, refWord(wordAddr));
    end
    @(negedge clk);
    compareValue("done_o", done, 1'b0);
    compareValue("ready_o", ready, 1'b1);
  endtask

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  // memory side addresses and writeback contents
  always @(negedge clk) begin
    if (rst_n && memRdValid) begin
      assert (memRdAddr === {curAddr[AddrWidth-1:OffsetWidth], 5'b0}) else begin
        busErrors++;
        $display("mismatch memRdAddr_o: got %h expected %h", memRdAddr,
                 {curAddr[AddrWidth-1:OffsetWidth], 5'b0});
      end
    end
    if (rst_n && memWrValid) begin
      assert (memWrAddr[IndexWidth+OffsetWidth-1:0] ===
              {curAddr[IndexWidth+OffsetWidth-1:OffsetWidth], 5'b0}) else begin
        busErrors++;
        $display("mismatch memWrAddr_o[10:0]: got %h expected %h",
                 memWrAddr[IndexWidth+OffsetWidth-1:0],
                 {curAddr[IndexWidth+OffsetWidth-1:OffsetWidth], 5'b0});
      end
      for (int w = 0; w < BeatsPerLine; w++) begin
        assert (memWrData[w] === refWord(memWrAddr + AddrWidth'(8 * w))) else begin
          busErrors++;
          $display("mismatch memWrData_o[%0d]: got %h expected %h", w, memWrData[w],
                   refWord(memWrAddr + AddrWidth'(8 * w)));
        end
      end
    end
  end

  initial begin
    rst_n = 1'b0;
    req = 1'b0;
    we = 1'b0;
    addr = '0;
    wrData = '0;
    wrMask = '0;
    loadTable();
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    compareValue("ready_o", ready, 1'b1);
    compareValue("done_o", done, 1'b0);
    compareValue("memRdValid_o", memRdValid, 1'b0);
    compareValue("memWrValid_o", memWrValid, 1'b0);
    for (int i = 0; i < NumEntries; i++) begin
      runEntry(i);
    end
    $display("errors: %0d data, %0d bus", dataErrors, busErrors);
    if (dataErrors == 0 && busErrors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin
    #((NumEntries * MissBound + 16) * ClkPeriod);
    $display("timeout: the table did not complete within %0d cycles",
             NumEntries * MissBound + 16);
    $display("errors: %0d data, %0d bus", dataErrors, busErrors);
    $display("Something failed");
    $finish;
  end

endmodule

// File: dcache.f
source/dcachePkg.sv
source/refillBuffer.sv
source/tagStore.sv
source/dataStore.sv
source/dcacheCtrl.sv
source/dcacheTop.sv
bench/tbMemory.sv
bench/dcacheTb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module dcacheTb -f dcache.f -o simv &&
./obj_dir/simv | tee /dev/stderr | grep -qx "Everything OK" &&
echo "simulation passed" || { echo "simulation failed"; exit 1; }
